// File: Bender.yml
package:
  name: store_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/store_queue.sv
      - hdl/store_lane_align.sv
      - hdl/dmem_write_ctrl.sv
      - hdl/store_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/store_unit_sva.sv
      - test/store_unit_tb.sv

// File: hdl/dmem_write_ctrl.sv
`timescale 1ns/10ps

module dmem_write_ctrl (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 head_valid,
    input  logic                 head_ready,
    input  lsu_pkg::rob_tag_t    head_tag,
    input  lsu_pkg::rob_tag_t    rob_head,
    input  lsu_pkg::dmem_wreq_t  wreq_in,
    output logic                 dmem_req_valid,
    output lsu_pkg::dmem_wreq_t  dmem_wreq,
    input  logic                 dmem_ack,
    output logic                 retire,
    output lsu_pkg::store_done_t store_done
);
    import lsu_pkg::*;

    typedef enum logic {
        st_idle,
        st_pending
    } state_e;

    state_e     state_q;
    dmem_wreq_t wreq_q;
    rob_tag_t   tag_q;
    logic       launch;

    // oldest store may only write once it is the rob head
    assign launch = head_valid && head_ready && (head_tag == rob_head);

    assign dmem_req_valid = !flush && ((state_q == st_pending) || launch);
    assign dmem_wreq      = (state_q == st_pending) ? wreq_q : wreq_in;
    assign retire         = dmem_req_valid && dmem_ack;

    assign store_done.valid = retire;
    assign store_done.tag   = (state_q == st_pending) ? tag_q : head_tag;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else if (flush) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (dmem_req_valid && !dmem_ack) begin
                        state_q <= st_pending;
                    end
                end
                st_pending: begin
                    if (dmem_ack) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // hold the request while memory stalls
    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && launch) begin
            wreq_q <= wreq_in;
            tag_q  <= head_tag;
        end
    end

endmodule

// File: hdl/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// store queue depth, eight entries by default
`define SQ_DEPTH_LOG2 3
`define SQ_ENTRIES (1 << `SQ_DEPTH_LOG2)

// reorder buffer tag width
`define ROB_TAG_W 3

// common data bus broadcast ports
`define CDB_PORTS 4

`endif

// File: hdl/lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

    // funct3 encoding of the store opcodes
    typedef enum logic [2:0] {
        store_sb = 3'b000,
        store_sh = 3'b001,
        store_sw = 3'b010
    } store_op_e;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    typedef struct packed {
        logic [29:0] index;
        logic [1:0]  offset;
    } mem_addr_fields_t;

    // byte address, whole or split into word index and byte lane
    typedef union packed {
        logic [31:0]      word;
        mem_addr_fields_t fields;
    } mem_addr_u;

    typedef struct packed {
        logic        regfile_ready;
        logic [31:0] regfile_value;
        logic        rob_ready;
        logic [31:0] rob_value;
        rob_tag_t    tag;
    } operand_src_t;

    typedef struct packed {
        store_op_e    op;
        logic [31:0]  imm;
        rob_tag_t     target;
        operand_src_t base;
        operand_src_t data;
    } sq_issue_t;

    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] value;
    } cdb_bcast_t;

    typedef struct packed {
        logic        ready;
        store_op_e   op;
        rob_tag_t    tag;
        logic [31:0] base;
        logic [31:0] imm;
        logic [31:0] data;
    } sq_head_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  mask;
        logic [31:0] data;
    } dmem_wreq_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } store_done_t;

endpackage

// File: hdl/store_lane_align.sv
`timescale 1ns/10ps

module store_lane_align (
    input  lsu_pkg::sq_head_t   head,
    output lsu_pkg::dmem_wreq_t wreq
);
    import lsu_pkg::*;

    mem_addr_u addr;

    assign addr.word = head.base + head.imm;

    always_comb begin
        // memory sees the byte address
        wreq.addr = addr.word;
        wreq.mask = '0;
        wreq.data = '0;
        case (head.op)
            store_sb: begin
                wreq.mask = 4'b0001 << addr.fields.offset;
                wreq.data = {24'b0, head.data[7:0]} << {addr.fields.offset, 3'b000};
            end
            store_sh: begin
                // halfword lane from offset bit 1 only
                wreq.mask = 4'b0011 << {addr.fields.offset[1], 1'b0};
                wreq.data = {16'b0, head.data[15:0]} << {addr.fields.offset[1], 4'b0000};
            end
            store_sw: begin
                wreq.mask = 4'b1111;
                wreq.data = head.data;
            end
            default: begin
                wreq.mask = '0;
                wreq.data = '0;
            end
        endcase
    end

endmodule

// File: hdl/store_queue.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module store_queue (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                issue_valid,
    input  lsu_pkg::sq_issue_t  issue,
    input  lsu_pkg::cdb_bcast_t cdb [`CDB_PORTS],
    input  logic                retire,
    output lsu_pkg::sq_head_t   head,
    output logic                head_valid,
    output logic                credit_return
);
    import lsu_pkg::*;

    typedef struct packed {
        logic        ready;
        rob_tag_t    tag;
        logic [31:0] value;
    } operand_t;

    typedef struct packed {
        store_op_e   op;
        rob_tag_t    target;
        logic [31:0] imm;
        operand_t    base;
        operand_t    data;
    } sq_entry_t;

    logic [`SQ_ENTRIES-1:0]   valid_q;
    sq_entry_t                entry_q [`SQ_ENTRIES];
    logic [`SQ_DEPTH_LOG2-1:0] wr_ptr;
    logic [`SQ_DEPTH_LOG2-1:0] rd_ptr;
    logic [`SQ_DEPTH_LOG2:0]   count_q;
    sq_entry_t                new_entry;
    logic                     pop;

    // regfile value wins over the rob bypass
    function automatic operand_t capture(operand_src_t src);
        operand_t res;
        res.tag = src.tag;
        if (src.regfile_ready) begin
            res.ready = 1'b1;
            res.value = src.regfile_value;
        end else if (src.rob_ready) begin
            res.ready = 1'b1;
            res.value = src.rob_value;
        end else begin
            res.ready = 1'b0;
            res.value = '0;
        end
        return res;
    endfunction

    always_comb begin
        new_entry.op     = issue.op;
        new_entry.target = issue.target;
        new_entry.imm    = issue.imm;
        new_entry.base   = capture(issue.base);
        new_entry.data   = capture(issue.data);
    end

    assign credit_return = retire && (count_q != '0);
    assign pop           = credit_return;

    // pointers, occupancy and valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
            valid_q <= '0;
        end else if (flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
            valid_q <= '0;
        end else begin
            if (pop) begin
                valid_q[rd_ptr] <= 1'b0;
                rd_ptr          <= rd_ptr + 1'b1;
            end
            if (issue_valid) begin
                valid_q[wr_ptr] <= 1'b1;
                wr_ptr          <= wr_ptr + 1'b1;
            end
            case ({issue_valid, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry payload: cdb wakeup, then allocation into the free slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `SQ_ENTRIES; i++) begin
            for (int j = 0; j < `CDB_PORTS; j++) begin
                if (valid_q[i] && cdb[j].valid) begin
                    if (!entry_q[i].base.ready && (entry_q[i].base.tag == cdb[j].tag)) begin
                        entry_q[i].base.ready <= 1'b1;
                        entry_q[i].base.value <= cdb[j].value;
                    end
                    if (!entry_q[i].data.ready && (entry_q[i].data.tag == cdb[j].tag)) begin
                        entry_q[i].data.ready <= 1'b1;
                        entry_q[i].data.value <= cdb[j].value;
                    end
                end
            end
        end
        if (issue_valid) begin
            entry_q[wr_ptr] <= new_entry;
        end
    end

    assign head_valid = valid_q[rd_ptr];

    always_comb begin
        head.ready = entry_q[rd_ptr].base.ready && entry_q[rd_ptr].data.ready;
        head.op    = entry_q[rd_ptr].op;
        head.tag   = entry_q[rd_ptr].target;
        head.base  = entry_q[rd_ptr].base.value;
        head.imm   = entry_q[rd_ptr].imm;
        head.data  = entry_q[rd_ptr].data.value;
    end

endmodule

// File: hdl/store_unit.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module store_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 issue_valid,
    input  lsu_pkg::sq_issue_t   issue,
    input  lsu_pkg::cdb_bcast_t  cdb [`CDB_PORTS],
    input  lsu_pkg::rob_tag_t    rob_head,
    output logic                 credit_return,
    output logic                 dmem_req_valid,
    output lsu_pkg::dmem_wreq_t  dmem_wreq,
    input  logic                 dmem_ack,
    output lsu_pkg::store_done_t store_done
);
    import lsu_pkg::*;

    sq_head_t   head;
    logic       head_valid;
    logic       retire;
    dmem_wreq_t aligned_wreq;

    store_queue store_queue_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .cdb           (cdb),
        .retire        (retire),
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    store_lane_align store_lane_align_i (
        .head (head),
        .wreq (aligned_wreq)
    );

    dmem_write_ctrl dmem_write_ctrl_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (flush),
        .head_valid     (head_valid),
        .head_ready     (head.ready),
        .head_tag       (head.tag),
        .rob_head       (rob_head),
        .wreq_in        (aligned_wreq),
        .dmem_req_valid (dmem_req_valid),
        .dmem_wreq      (dmem_wreq),
        .dmem_ack       (dmem_ack),
        .retire         (retire),
        .store_done     (store_done)
    );

endmodule

// File: test/store_unit_sva.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module store_unit_sva (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 flush,
    input logic                 issue_valid,
    input logic                 credit_return,
    input logic                 dmem_req_valid,
    input lsu_pkg::dmem_wreq_t  dmem_wreq,
    input logic                 dmem_ack,
    input lsu_pkg::store_done_t store_done
);

    logic [`SQ_DEPTH_LOG2:0] occupancy;

    // fill level seen from the issue side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupancy <= '0;
        end else if (flush) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + issue_valid - credit_return;
        end
    end

    req_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_req_valid && !dmem_ack && !flush |=>
            flush || (dmem_req_valid && $stable(dmem_wreq)))
        else $error("memory request dropped or changed before ack");

    done_needs_store_a: assert property (@(posedge clk) disable iff (!arst_n)
        store_done.valid |-> occupancy != '0)
        else $error("store completed with no store in the queue");

    credit_on_done_a: assert property (@(posedge clk) disable iff (!arst_n)
        credit_return == store_done.valid)
        else $error("credit_return differs from store_done.valid");

    no_overflow_a: assert property (@(posedge clk) disable iff (!arst_n)
        issue_valid && !flush |-> occupancy < `SQ_ENTRIES)
        else $error("store allocated into a full queue");

    flush_quiet_a: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !dmem_req_valid && !credit_return)
        else $error("request or credit right after flush");

endmodule

// File: test/store_unit_tb.sv
`timescale 1ns/10ps
`include "lsu_defs.svh"

module store_unit_tb;
    import lsu_pkg::*;

    typedef struct {
        logic [31:0] addr;
        logic [3:0]  mask;
        logic [31:0] data;
        rob_tag_t    tag;
    } exp_req_t;

    // a few hundred cycles of tests, with ample margin
    localparam int timeout_cycles = 3000;

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic        issue_valid;
    sq_issue_t   issue;
    cdb_bcast_t  cdb [`CDB_PORTS];
    rob_tag_t    rob_head;
    logic        credit_return;
    logic        dmem_req_valid;
    dmem_wreq_t  dmem_wreq;
    logic        dmem_ack;
    store_done_t store_done;

    exp_req_t    exp_q [$];
    dmem_wreq_t  held_wreq;
    logic        held;
    logic [7:0]  lfsr;
    int          wait_left;
    int          credits;
    int          credit_pulses;
    int          errors;
    int          checks;
    int          tests;
    int          cycles;
    logic        rob_advance;
    rob_tag_t    rob_next;
    rob_tag_t    next_tag;

    store_unit store_unit_i (.*);

    bind store_unit store_unit_sva store_unit_sva_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic take_random_bit();
        lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        return lfsr[0];
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t %s got 0x%08h expected 0x%08h", $time, name, got, want);
        end
    endtask

    // byte lanes from the low bytes of the value, starting at the lane offset
    function automatic exp_req_t lane_expect(store_op_e op, logic [31:0] base, logic [31:0] imm,
                                             logic [31:0] value, rob_tag_t tag);
        exp_req_t r;
        int       n;
        int       lo;
        r.addr = base + imm;
        r.mask = '0;
        r.data = '0;
        r.tag  = tag;
        n  = (op == store_sb) ? 1 : (op == store_sh) ? 2 : 4;
        lo = int'(r.addr[1:0]) & ~(n - 1);
        for (int b = 0; b < n; b++) begin
            r.mask[lo + b]            = 1'b1;
            r.data[8 * (lo + b) +: 8] = value[8 * b +: 8];
        end
        return r;
    endfunction

    // mode 0 pending, 1 regfile, 2 rob bypass, 3 both with regfile winning
    function automatic operand_src_t make_src(int mode, logic [31:0] value, rob_tag_t tag);
        operand_src_t s;
        s.regfile_ready = (mode == 1) || (mode == 3);
        s.regfile_value = (mode == 2) ? ~value : value;
        s.rob_ready     = (mode >= 2);
        s.rob_value     = (mode == 3) ? ~value : value;
        s.tag           = tag;
        return s;
    endfunction

    task automatic issue_store(store_op_e op, logic [31:0] imm, rob_tag_t target,
                               operand_src_t base_src, operand_src_t data_src);
        @(negedge clk);
        while (credits == 0) begin
            @(negedge clk);
        end
        issue_valid  = 1'b1;
        issue.op     = op;
        issue.imm    = imm;
        issue.target = target;
        issue.base   = base_src;
        issue.data   = data_src;
        credits--;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic broadcast(int port, rob_tag_t tag, logic [31:0] value);
        @(negedge clk);
        cdb[port] = {1'b1, tag, value};
        @(negedge clk);
        cdb[port].valid = 1'b0;
    endtask

    task automatic wait_drain();
        do begin
            @(negedge clk);
        end while (exp_q.size() != 0);
        @(negedge clk);
    endtask

    task automatic expect_quiet(int n);
        repeat (n) begin
            @(posedge clk);
            compare_value("dmem_req_valid", dmem_req_valid, 1'b0);
            compare_value("store_done.valid", store_done.valid, 1'b0);
            compare_value("credit_return", credit_return, 1'b0);
        end
    endtask

    task automatic finish_test(string name, int start_errors);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - start_errors);
    endtask

    // one store held back by rob_head, then released and drained
    task automatic run_store(store_op_e op, logic [31:0] base, logic [31:0] imm,
                             logic [31:0] value, int base_mode, int data_mode);
        rob_tag_t tag;
        tag = next_tag;
        next_tag++;
        @(negedge clk);
        rob_head = rob_tag_t'(tag + 3);
        exp_q.push_back(lane_expect(op, base, imm, value, tag));
        issue_store(op, imm, tag, make_src(base_mode, base, '0), make_src(data_mode, value, '0));
        expect_quiet(3);
        @(negedge clk);
        rob_head = tag;
        wait_drain();
    endtask

    // memory model and response checks, sampled before the edge
    always @(posedge clk) begin
        exp_req_t e;
        if (arst_n) begin
            if (held && !flush) begin
                compare_value("held dmem_req_valid", dmem_req_valid, 1'b1);
                compare_value("held dmem_wreq.addr", dmem_wreq.addr, held_wreq.addr);
                compare_value("held dmem_wreq.mask", dmem_wreq.mask, held_wreq.mask);
                compare_value("held dmem_wreq.data", dmem_wreq.data, held_wreq.data);
            end
            compare_value("store_done.valid", store_done.valid, dmem_req_valid && dmem_ack);
            compare_value("credit_return", credit_return, dmem_req_valid && dmem_ack);
            if (credit_return) begin
                credits++;
                credit_pulses++;
            end
            if (dmem_req_valid && dmem_ack) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR %0t memory write with no store outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    compare_value("dmem_wreq.addr", dmem_wreq.addr, e.addr);
                    compare_value("dmem_wreq.mask", dmem_wreq.mask, e.mask);
                    compare_value("dmem_wreq.data", dmem_wreq.data, e.data);
                    compare_value("store_done.tag", store_done.tag, e.tag);
                    rob_next    = rob_tag_t'(e.tag + 1);
                    rob_advance = 1'b1;
                end
                wait_left = {take_random_bit(), take_random_bit()};
            end else if (dmem_req_valid && (wait_left != 0)) begin
                wait_left--;
            end
            held      = dmem_req_valid && !dmem_ack;
            held_wreq = dmem_wreq;
        end
    end

    // ack after the drawn number of waiting cycles, rob commits the store
    always @(negedge clk) begin
        dmem_ack = (wait_left == 0);
        if (rob_advance) begin
            rob_head    = rob_next;
            rob_advance = 1'b0;
        end
    end

    task automatic idle_after_reset();
        int start;
        start = errors;
        expect_quiet(6);
        finish_test("idle after reset", start);
    endtask

    task automatic lane_alignment();
        int start;
        start = errors;
        run_store(store_sw, 32'h0000_2000, 32'h0000_0010, 32'hcafe_f00d, 1, 2);
        for (int off = 0; off < 4; off++) begin
            run_store(store_sb, 32'h0000_3001, off - 1, 32'h1234_56a0 + off, 2, 3);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_store(store_sh, 32'h0000_4000, off, 32'h89ab_cd00 + off, 3, 1);
        end
        finish_test("lane alignment", start);
    endtask

    task automatic cdb_wakeup();
        int       start;
        rob_tag_t tag;
        rob_tag_t base_tag;
        rob_tag_t data_tag;
        start    = errors;
        tag      = next_tag;
        next_tag++;
        base_tag = rob_tag_t'(tag - 2);
        data_tag = rob_tag_t'(tag - 1);
        @(negedge clk);
        rob_head = tag;
        exp_q.push_back(lane_expect(store_sw, 32'h0000_5000, 32'h24, 32'h5a5a_0f0f, tag));
        issue_store(store_sw, 32'h24, tag, make_src(0, 32'hbad0_bad0, base_tag),
                    make_src(0, 32'hbad1_bad1, data_tag));
        broadcast(0, rob_tag_t'(tag + 3), 32'hffff_ffff);
        expect_quiet(2);
        broadcast(1, base_tag, 32'h0000_5000);
        expect_quiet(2);
        broadcast(3, data_tag, 32'h5a5a_0f0f);
        wait_drain();
        finish_test("cdb wakeup", start);
    endtask

    task automatic fill_and_drain();
        int        start;
        int        pulses;
        rob_tag_t  first;
        store_op_e op;
        start  = errors;
        pulses = credit_pulses;
        first  = next_tag;
        @(negedge clk);
        rob_head = rob_tag_t'(first + 1);
        for (int i = 0; i < `SQ_ENTRIES; i++) begin
            op = (i % 3 == 0) ? store_sb : (i % 3 == 1) ? store_sh : store_sw;
            exp_q.push_back(lane_expect(op, 32'h0000_6000, 4 * i, 32'h1111_1111 * (i + 1),
                                        next_tag));
            issue_store(op, 4 * i, next_tag, make_src(1, 32'h0000_6000, '0),
                        make_src(2, 32'h1111_1111 * (i + 1), '0));
            next_tag++;
        end
        compare_value("credits after fill", credits, 0);
        @(negedge clk);
        rob_head = first;
        wait_drain();
        compare_value("credit_return pulses", credit_pulses - pulses, `SQ_ENTRIES);
        compare_value("credits after drain", credits, `SQ_ENTRIES);
        finish_test("fill and drain", start);
    endtask

    task automatic flush_recovery();
        int       start;
        rob_tag_t first;
        start = errors;
        first = next_tag;
        @(negedge clk);
        rob_head = rob_tag_t'(first + 1);
        for (int i = 0; i < 3; i++) begin
            issue_store(store_sw, 4 * i, rob_tag_t'(first + i), make_src(1, 32'h0000_7000, '0),
                        make_src(1, 32'h7777_0000 + i, '0));
        end
        @(negedge clk);
        flush   = 1'b1;
        credits = `SQ_ENTRIES;
        @(negedge clk);
        flush    = 1'b0;
        rob_head = first;
        expect_quiet(4);
        // flushed tags are free again
        run_store(store_sh, 32'h0000_7000, 32'h2, 32'h0000_beef, 1, 1);
        compare_value("credits after flush", credits, `SQ_ENTRIES);
        finish_test("flush recovery", start);
    endtask

    initial begin
        arst_n        = 1'b0;
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issue         = '0;
        rob_head      = '0;
        dmem_ack      = 1'b0;
        lfsr          = 8'd51;
        credits       = `SQ_ENTRIES;
        credit_pulses = 0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        held          = 1'b0;
        rob_advance   = 1'b0;
        rob_next      = '0;
        next_tag      = '0;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            cdb[p] = '0;
        end
        wait_left = {take_random_bit(), take_random_bit()};
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        idle_after_reset();
        lane_alignment();
        cdb_wakeup();
        fill_and_drain();
        flush_recovery();
        repeat (4) @(negedge clk);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/store_queue.sv
hdl/store_lane_align.sv
hdl/dmem_write_ctrl.sv
hdl/store_unit.sv
test/store_unit_sva.sv
test/store_unit_tb.sv
